// ==== include/boot_rom_init.svh ====
`ifndef BOOT_ROM_INIT_SVH
`define BOOT_ROM_INIT_SVH

// Boot image, one OR1K instruction per word
function automatic logic [WB_DW-1:0] boot_rom_word(input logic [ROM_AW-1:0] word_adr);
	logic [WB_DW-1:0] word;
	case (word_adr)
		6'd0:    word = 32'h1800_0000;
		6'd1:    word = 32'h1820_9100;
		6'd2:    word = 32'ha821_0000;
		6'd3:    word = 32'h9c60_00f0;
		6'd4:    word = 32'hd801_1801;
		6'd5:    word = 32'h9c60_00a5;
		6'd6:    word = 32'hd801_1800;
		6'd7:    word = 32'h9c60_0001;
		6'd8:    word = 32'hd801_1802;
		6'd9:    word = 32'h18a0_f000;
		6'd10:   word = 32'ha8a5_0100;
		6'd11:   word = 32'h4400_2800;
		6'd12:   word = 32'h1500_0000;
		6'd13:   word = 32'hdead_beef;
		6'd14:   word = 32'h0123_4567;
		6'd15:   word = 32'h89ab_cdef;
		// Rest of the ROM is filled with l.nop
		default: word = 32'h1500_0000;
	endcase
	return word;
endfunction

`endif

// ==== source/soc_pkg.sv ====
package soc_pkg;

	////////////////////////////////////////////////////////////
	// Bus and peripheral widths
	////////////////////////////////////////////////////////////
	localparam int WB_DW    = 32;
	localparam int WB_AW    = 32;
	localparam int WB_SW    = 4;
	localparam int GPIO_W   = 8;
	localparam int GPIO_RAW = 2;
	localparam int ROM_AW   = 6;

	// First address bit above the ROM's 256 bytes
	localparam int ROM_LSB  = ROM_AW + 2;

	////////////////////////////////////////////////////////////
	// Address map and interrupt lines
	////////////////////////////////////////////////////////////
	localparam logic [WB_AW-1:0] ROM_BASE  = 32'hf000_0000;
	localparam logic [WB_AW-1:0] GPIO_BASE = 32'h9100_0000;

	localparam int PIC_INTS      = 20;
	localparam int GPIO_IRQ_LINE = 10;

	////////////////////////////////////////////////////////////
	// Bus records
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [WB_AW-1:0] adr;
		logic [WB_DW-1:0] dat;
		logic [WB_SW-1:0] sel;
		logic             we;
		logic             cyc;
		logic             stb;
	} wb_m2s_t;

	typedef struct packed {
		logic [WB_DW-1:0] dat;
		logic             ack;
		logic             err;
	} wb_s2m_t;

	// 8-bit side, adr is the register offset
	typedef struct packed {
		logic [GPIO_RAW-1:0] adr;
		logic [GPIO_W-1:0]   dat;
		logic                we;
		logic                cyc;
		logic                stb;
	} wb8_m2s_t;

	typedef struct packed {
		logic [GPIO_W-1:0] dat;
		logic              ack;
	} wb8_s2m_t;

	typedef enum logic [GPIO_RAW-1:0] {
		GPIO_DATA = 2'd0,
		GPIO_DIR  = 2'd1,
		GPIO_MASK = 2'd2,
		GPIO_STAT = 2'd3
	} gpio_reg_e;

endpackage

// ==== source/wb_addr_decode.sv ====
`timescale 1ns/10ps

module wb_addr_decode (
	input  logic             wb_clk_i,
	input  logic             rst_n_i,
	input  soc_pkg::wb_m2s_t wb_i,
	output soc_pkg::wb_s2m_t wb_o,
	output soc_pkg::wb_m2s_t rom_req_o,
	input  soc_pkg::wb_s2m_t rom_rsp_i,
	output soc_pkg::wb_m2s_t gpio_req_o,
	input  soc_pkg::wb_s2m_t gpio_rsp_i
);
	import soc_pkg::*;

	logic rom_hit;
	logic gpio_hit;
	logic miss;
	logic err_q;

	assign rom_hit  = (wb_i.adr[WB_AW-1:ROM_LSB] == ROM_BASE[WB_AW-1:ROM_LSB]);
	assign gpio_hit = (wb_i.adr[WB_AW-1:2] == GPIO_BASE[WB_AW-1:2]);
	assign miss     = wb_i.cyc & wb_i.stb & ~rom_hit & ~gpio_hit;

	// Only the matching slave sees a strobe
	always_comb begin
		rom_req_o      = wb_i;
		rom_req_o.cyc  = wb_i.cyc & rom_hit;
		rom_req_o.stb  = wb_i.stb & rom_hit;
		gpio_req_o     = wb_i;
		gpio_req_o.cyc = wb_i.cyc & gpio_hit;
		gpio_req_o.stb = wb_i.stb & gpio_hit;
	end

	// Response merge
	always_comb begin
		if (rom_hit) begin
			wb_o.dat = rom_rsp_i.dat;
		end else if (gpio_hit) begin
			wb_o.dat = gpio_rsp_i.dat;
		end else begin
			wb_o.dat = '0;
		end
		wb_o.ack = rom_rsp_i.ack | gpio_rsp_i.ack;
		wb_o.err = err_q;
	end

	// Unmapped strobe, one cycle error pulse
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= miss & ~err_q;
		end
	end

	a_ack_err_excl: assert property (
		@(posedge wb_clk_i) disable iff (!rst_n_i)
		!(wb_o.ack && wb_o.err)
	);

	// Every slave answers one cycle after the strobe shows up
	a_one_cycle_rsp: assert property (
		@(posedge wb_clk_i) disable iff (!rst_n_i)
		$rose(wb_i.cyc && wb_i.stb) |=> (wb_o.ack || wb_o.err)
	);

endmodule

// ==== source/wb_data_resize.sv ====
`timescale 1ns/10ps

module wb_data_resize (
	input  soc_pkg::wb_m2s_t  wbm_i,
	output soc_pkg::wb_s2m_t  wbm_o,
	output soc_pkg::wb8_m2s_t wbs_o,
	input  soc_pkg::wb8_s2m_t wbs_i
);
	import soc_pkg::*;

	// Big-endian lanes, sel[3] is offset 0
	always_comb begin
		wbs_o.we  = wbm_i.we;
		wbs_o.cyc = wbm_i.cyc;
		wbs_o.stb = wbm_i.stb;
		wbs_o.adr = '0;
		wbs_o.dat = wbm_i.dat[WB_DW-1 -: GPIO_W];
		for (int lane = 0; lane < WB_SW; lane++) begin
			if (wbm_i.sel[lane]) begin
				wbs_o.adr = GPIO_RAW'(WB_SW - 1 - lane);
				wbs_o.dat = wbm_i.dat[lane*GPIO_W +: GPIO_W];
			end
		end
	end

	// Read byte shows on every lane
	always_comb begin
		wbm_o.dat = {WB_SW{wbs_i.dat}};
		wbm_o.ack = wbs_i.ack;
		wbm_o.err = 1'b0;
	end

	// Byte-wide slave, one lane per access
	always_comb begin
		a_single_lane: assert final (!(wbm_i.cyc && wbm_i.stb) || $onehot(wbm_i.sel));
	end

endmodule

// ==== source/boot_rom.sv ====
`timescale 1ns/10ps

module boot_rom (
	input  logic             wb_clk_i,
	input  logic             rst_n_i,
	input  soc_pkg::wb_m2s_t wb_i,
	output soc_pkg::wb_s2m_t wb_o
);
	import soc_pkg::*;

	`include "boot_rom_init.svh"

	logic [ROM_AW-1:0] word_adr;
	logic [WB_DW-1:0]  dat_q;
	logic              ack_q;
	logic              access;

	assign word_adr = wb_i.adr[ROM_LSB-1:2];
	assign access   = wb_i.cyc & wb_i.stb & ~ack_q;

	// Writes get an ack and are dropped
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			dat_q <= boot_rom_word(word_adr);
		end
	end

	assign wb_o.dat = dat_q;
	assign wb_o.ack = ack_q;
	assign wb_o.err = 1'b0;

endmodule

// ==== source/gpio_regs.sv ====
`timescale 1ns/10ps

module gpio_regs (
	input  logic                       wb_clk_i,
	input  logic                       rst_n_i,
	input  soc_pkg::wb8_m2s_t          wb_i,
	output soc_pkg::wb8_s2m_t          wb_o,
	input  logic [soc_pkg::GPIO_W-1:0] pin_i,
	input  logic [soc_pkg::GPIO_W-1:0] rise_i,
	output logic [soc_pkg::GPIO_W-1:0] out_o,
	output logic [soc_pkg::GPIO_W-1:0] dir_o,
	output logic                       irq_o
);
	import soc_pkg::*;

	logic [GPIO_W-1:0] out_q;
	logic [GPIO_W-1:0] dir_q;
	logic [GPIO_W-1:0] mask_q;
	logic [GPIO_W-1:0] stat_q;
	logic [GPIO_W-1:0] stat_clr;
	logic [GPIO_W-1:0] rd_data;
	logic [GPIO_W-1:0] rd_q;
	logic              ack_q;
	logic              access;
	logic              wr_en;
	gpio_reg_e         reg_sel;

	assign access  = wb_i.cyc & wb_i.stb & ~ack_q;
	assign wr_en   = access & wb_i.we;
	assign reg_sel = gpio_reg_e'(wb_i.adr);

	////////////////////////////////////////////////////////////
	// Read path
	////////////////////////////////////////////////////////////
	always_comb begin
		case (reg_sel)
			// Outputs read back the register, inputs the pin
			GPIO_DATA: rd_data = (out_q & dir_q) | (pin_i & ~dir_q);
			GPIO_DIR:  rd_data = dir_q;
			GPIO_MASK: rd_data = mask_q;
			default:   rd_data = stat_q;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (access) begin
			rd_q <= rd_data;
		end
	end

	////////////////////////////////////////////////////////////
	// Control registers
	////////////////////////////////////////////////////////////
	assign stat_clr = (wr_en && reg_sel == GPIO_STAT) ? wb_i.dat : '0;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q  <= 1'b0;
			out_q  <= '0;
			dir_q  <= '0;
			mask_q <= '0;
			stat_q <= '0;
		end else begin
			ack_q  <= access;
			// New edge beats a clear
			stat_q <= (stat_q & ~stat_clr) | rise_i;
			if (wr_en) begin
				case (reg_sel)
					GPIO_DATA: out_q  <= wb_i.dat;
					GPIO_DIR:  dir_q  <= wb_i.dat;
					GPIO_MASK: mask_q <= wb_i.dat;
					default:   ;
				endcase
			end
		end
	end

	assign out_o     = out_q;
	assign dir_o     = dir_q;
	assign irq_o     = |(stat_q & mask_q);
	assign wb_o.dat  = rd_q;
	assign wb_o.ack  = ack_q;

	a_ack_in_strobe: assert property (
		@(posedge wb_clk_i) disable iff (!rst_n_i)
		wb_o.ack |-> (wb_i.cyc && wb_i.stb)
	);

endmodule

// ==== source/gpio_pads.sv ====
`timescale 1ns/10ps

module gpio_pads (
	input  logic                       wb_clk_i,
	input  logic                       rst_n_i,
	inout  wire  [soc_pkg::GPIO_W-1:0] gpio_io,
	input  logic [soc_pkg::GPIO_W-1:0] out_i,
	input  logic [soc_pkg::GPIO_W-1:0] dir_i,
	output logic [soc_pkg::GPIO_W-1:0] pin_o,
	output logic [soc_pkg::GPIO_W-1:0] rise_o
);
	import soc_pkg::*;

	logic [GPIO_W-1:0] meta_q;
	logic [GPIO_W-1:0] sync_q;
	logic [GPIO_W-1:0] last_q;

	// Tristate, 1 = output
	for (genvar i = 0; i < GPIO_W; i++) begin : g_tris
		assign gpio_io[i] = dir_i[i] ? out_i[i] : 1'bz;
	end

	// Two flop synchronizer plus previous value
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			meta_q <= '0;
			sync_q <= '0;
			last_q <= '0;
		end else begin
			meta_q <= gpio_io;
			sync_q <= meta_q;
			last_q <= sync_q;
		end
	end

	assign pin_o  = sync_q;
	assign rise_o = sync_q & ~last_q;

endmodule

// ==== source/orpsoc_top.sv ====
`timescale 1ns/10ps

module orpsoc_top (
	input  logic                         wb_clk_i,
	input  logic                         rst_n_i,
	input  soc_pkg::wb_m2s_t             wb_i,
	output soc_pkg::wb_s2m_t             wb_o,
	inout  wire  [soc_pkg::GPIO_W-1:0]   gpio_io,
	output logic [soc_pkg::PIC_INTS-1:0] pic_ints_o
);
	import soc_pkg::*;

	wb_m2s_t           rom_req;
	wb_s2m_t           rom_rsp;
	wb_m2s_t           gpio_req;
	wb_s2m_t           gpio_rsp;
	wb8_m2s_t          gpio8_req;
	wb8_s2m_t          gpio8_rsp;
	logic [GPIO_W-1:0] gpio_out;
	logic [GPIO_W-1:0] gpio_dir;
	logic [GPIO_W-1:0] gpio_pin;
	logic [GPIO_W-1:0] gpio_rise;
	logic              gpio_irq;

	////////////////////////////////////////////////////////////
	// Address decode and boot ROM
	////////////////////////////////////////////////////////////
	wb_addr_decode decode0 (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.wb_i       (wb_i),
		.wb_o       (wb_o),
		.rom_req_o  (rom_req),
		.rom_rsp_i  (rom_rsp),
		.gpio_req_o (gpio_req),
		.gpio_rsp_i (gpio_rsp)
	);

	boot_rom rom0 (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.wb_i     (rom_req),
		.wb_o     (rom_rsp)
	);

	////////////////////////////////////////////////////////////
	// GPIO 0
	////////////////////////////////////////////////////////////
	// 32 to 8 bit bridge
	wb_data_resize wb_data_resize_gpio0 (
		.wbm_i (gpio_req),
		.wbm_o (gpio_rsp),
		.wbs_o (gpio8_req),
		.wbs_i (gpio8_rsp)
	);

	gpio_regs gpio0_regs (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.wb_i     (gpio8_req),
		.wb_o     (gpio8_rsp),
		.pin_i    (gpio_pin),
		.rise_i   (gpio_rise),
		.out_o    (gpio_out),
		.dir_o    (gpio_dir),
		.irq_o    (gpio_irq)
	);

	gpio_pads gpio0_pads (
		.wb_clk_i (wb_clk_i),
		.rst_n_i  (rst_n_i),
		.gpio_io  (gpio_io),
		.out_i    (gpio_out),
		.dir_i    (gpio_dir),
		.pin_o    (gpio_pin),
		.rise_o   (gpio_rise)
	);

	////////////////////////////////////////////////////////////
	// Interrupt vector
	////////////////////////////////////////////////////////////
	// Lines 0 and 1 are non-maskable on the OR1200, left at zero
	always_comb begin
		pic_ints_o                = '0;
		pic_ints_o[GPIO_IRQ_LINE] = gpio_irq;
	end

endmodule

// ==== tb/orpsoc_tb.sv ====
`timescale 1ns/10ps

module orpsoc_tb;
	import soc_pkg::*;

	localparam time CLK_PERIOD   = 20;
	localparam int  RESET_CYCLES = 10;
	localparam int  CYCLES_PER_OP = 50;

	logic                wb_clk_i;
	logic                rst_n_i;
	wb_m2s_t             wb_m;
	wb_s2m_t             wb_s;
	wire  [GPIO_W-1:0]   gpio_io;
	logic [PIC_INTS-1:0] pic_ints;

	// Testbench pad drivers
	logic [GPIO_W-1:0] pad_val;
	logic [GPIO_W-1:0] pad_en;

	// Expected GPIO state, tracked from bus writes
	logic [GPIO_W-1:0] model_out;
	logic [GPIO_W-1:0] model_dir;

	logic [63:0] op_q[$];
	logic [31:0] adr_q[$];
	logic [31:0] sel_q[$];
	logic [31:0] dat_q[$];
	logic [31:0] exp_q[$];

	integer seed;
	int     errors;
	logic   stim_loaded;

	orpsoc_top orpsoc_top_inst (
		.wb_clk_i   (wb_clk_i),
		.rst_n_i    (rst_n_i),
		.wb_i       (wb_m),
		.wb_o       (wb_s),
		.gpio_io    (gpio_io),
		.pic_ints_o (pic_ints)
	);

	for (genvar i = 0; i < GPIO_W; i++) begin : g_pad
		assign gpio_io[i] = pad_en[i] ? pad_val[i] : 1'bz;
	end

	initial begin
		wb_clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;
	end

	////////////////////////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////////////////////////
	task automatic load_stimulus();
		int          fd;
		int          n;
		logic        done;
		logic [63:0] op_txt;
		logic [8*256-1:0] skip;
		logic [31:0] a;
		logic [31:0] s;
		logic [31:0] d;
		logic [31:0] e;
		done = 1'b0;
		fd = $fopen("tb/orpsoc_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open the stimulus file tb/orpsoc_stimulus.txt");
			errors++;
			return;
		end
		while (!done) begin
			n = $fscanf(fd, " %s", op_txt);
			if (n != 1) begin
				done = 1'b1;
			end else if (op_txt == "#") begin
				n = $fgets(skip, fd);
			end else begin
				n = $fscanf(fd, " %h %h %h %h", a, s, d, e);
				if (n != 4) begin
					$display("Stimulus line %0d is malformed", op_q.size() + 1);
					errors++;
					done = 1'b1;
				end else begin
					op_q.push_back(op_txt);
					adr_q.push_back(a);
					sel_q.push_back(s);
					dat_q.push_back(d);
					exp_q.push_back(e);
				end
			end
		end
		$fclose(fd);
	endtask

	////////////////////////////////////////////////////////////
	// Bus master
	////////////////////////////////////////////////////////////
	// Called on a falling edge, returns on a falling edge
	task automatic bus_access(input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat, input logic we, output logic got_ack,
			output logic got_err, output logic [31:0] rdat);
		int waited;
		got_ack = 1'b0;
		got_err = 1'b0;
		rdat    = '0;
		waited  = 0;
		wb_m.adr = adr;
		wb_m.sel = sel;
		wb_m.dat = dat;
		wb_m.we  = we;
		wb_m.cyc = 1'b1;
		wb_m.stb = 1'b1;
		while (!got_ack && !got_err && waited < 4) begin
			@(negedge wb_clk_i);
			waited++;
			got_ack = wb_s.ack;
			got_err = wb_s.err;
			rdat    = wb_s.dat;
		end
		if (got_ack || got_err) begin
			// Strobe stays up through the edge that samples the acknowledge
			@(negedge wb_clk_i);
		end
		wb_m.cyc = 1'b0;
		wb_m.stb = 1'b0;
		wb_m.we  = 1'b0;
		if (!got_ack && !got_err) begin
			$display("Bus hung: no ack or err within 4 cycles for address %h", adr);
			errors++;
		end
		// One idle cycle between transfers
		@(negedge wb_clk_i);
	endtask

	// Byte lanes are big-endian
	task automatic note_gpio_write(input logic [31:0] adr, input logic [3:0] sel,
			input logic [31:0] dat);
		logic [1:0] off;
		logic [7:0] wbyte;
		off   = 2'd0;
		wbyte = dat[31:24];
		case (sel)
			4'b0100: begin
				off   = 2'd1;
				wbyte = dat[23:16];
			end
			4'b0010: begin
				off   = 2'd2;
				wbyte = dat[15:8];
			end
			4'b0001: begin
				off   = 2'd3;
				wbyte = dat[7:0];
			end
			default: ;
		endcase
		if (adr[31:2] == GPIO_BASE[31:2]) begin
			if (off == 2'd0) begin
				model_out = wbyte;
			end
			if (off == 2'd1) begin
				model_dir = wbyte;
			end
		end
	endtask

	// Expected pin levels from the GPIO model and the pad drivers
	task automatic check_pins();
		logic [GPIO_W-1:0] exp_pins;
		for (int i = 0; i < GPIO_W; i++) begin
			if (model_dir[i]) begin
				exp_pins[i] = model_out[i];
			end else if (pad_en[i]) begin
				exp_pins[i] = pad_val[i];
			end else begin
				exp_pins[i] = 1'bz;
			end
		end
		if (gpio_io !== exp_pins) begin
			$display("[ERROR] %0t: pins read %b, expected %b", $time, gpio_io, exp_pins);
			errors++;
		end
	endtask

	task automatic run_op(input int idx);
		logic [63:0] op;
		logic [31:0] adr;
		logic [3:0]  sel;
		logic [31:0] dat;
		logic [31:0] exp;
		logic        ack;
		logic        err;
		logic [31:0] rdat;
		logic [7:0]  rnd_byte;
		logic [7:0]  exp_byte;
		op  = op_q[idx];
		adr = adr_q[idx];
		sel = sel_q[idx][3:0];
		dat = dat_q[idx];
		exp = exp_q[idx];
		case (op)
			"rd": begin
				bus_access(adr, sel, '0, 1'b0, ack, err, rdat);
				if (err) begin
					$display("[ERROR] %0t: read of %h returned err", $time, adr);
					errors++;
				end else if (ack && rdat !== exp) begin
					$display("[ERROR] %0t: read of %h returned %h, expected %h",
						$time, adr, rdat, exp);
					errors++;
				end
			end
			"rde": begin
				bus_access(adr, sel, '0, 1'b0, ack, err, rdat);
				if (ack) begin
					$display("[ERROR] %0t: read of %h returned ack, expected err", $time, adr);
					errors++;
				end
			end
			"wr": begin
				bus_access(adr, sel, dat, 1'b1, ack, err, rdat);
				if (err) begin
					$display("[ERROR] %0t: write to %h returned err", $time, adr);
					errors++;
				end
				note_gpio_write(adr, sel, dat);
			end
			"pad": begin
				pad_val = dat[GPIO_W-1:0];
				pad_en  = exp[GPIO_W-1:0];
			end
			"rnd": begin
				rnd_byte = $random(seed);
				pad_en   = dat[GPIO_W-1:0];
				pad_val  = rnd_byte & dat[GPIO_W-1:0];
				repeat (4) @(negedge wb_clk_i);
				exp_byte = (model_out & model_dir) | (pad_val & pad_en & ~model_dir);
				bus_access(adr, sel, '0, 1'b0, ack, err, rdat);
				if (err) begin
					$display("[ERROR] %0t: pad read of %h returned err", $time, adr);
					errors++;
				end else if (ack && rdat !== {4{exp_byte}}) begin
					$display("[ERROR] %0t: pad read returned %h, expected %h",
						$time, rdat, {4{exp_byte}});
					errors++;
				end
			end
			"wait": begin
				repeat (dat) @(negedge wb_clk_i);
				check_pins();
			end
			"irq": begin
				repeat (dat) @(negedge wb_clk_i);
				if (pic_ints !== exp[PIC_INTS-1:0]) begin
					$display("[ERROR] %0t: interrupt vector %h, expected %h",
						$time, pic_ints, exp[PIC_INTS-1:0]);
					errors++;
				end
			end
			default: begin
				$display("Unknown operation in stimulus entry %0d", idx + 1);
				errors++;
			end
		endcase
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		errors      = 0;
		seed        = 39;
		stim_loaded = 1'b0;
		rst_n_i     = 1'b0;
		wb_m        = '0;
		pad_val     = '0;
		pad_en      = '1;
		model_out   = '0;
		model_dir   = '0;
		load_stimulus();
		stim_loaded = 1'b1;
		repeat (RESET_CYCLES) @(negedge wb_clk_i);
		rst_n_i = 1'b1;
		@(negedge wb_clk_i);
		if (pic_ints !== '0) begin
			$display("[ERROR] %0t: interrupt vector %h after reset", $time, pic_ints);
			errors++;
		end
		if (wb_s.ack !== 1'b0 || wb_s.err !== 1'b0) begin
			$display("[ERROR] %0t: ack or err high after reset", $time);
			errors++;
		end
		for (int i = 0; i < op_q.size(); i++) begin
			run_op(i);
		end
		$display("Run finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (stim_loaded);
		#((op_q.size() * CYCLES_PER_OP + RESET_CYCLES) * CLK_PERIOD);
		$display("Watchdog timeout: the run did not finish in time");
		$display("Something failed");
		$finish;
	end

endmodule

// ==== tb/orpsoc_stimulus.txt ====
# Columns: op addr sel data expect, all numbers in hex
# rd, rde: read expecting ack with data = expect, or expecting err
# wr: write data, pad: drive data on the pins set in expect
# rnd: random values on pins in data, wait 4 cycles, then read GPIO data
# wait: idle data cycles, irq: idle data cycles, then compare vector with expect
rde  80000000 f 00000000 00000000
rde  f0000100 f 00000000 00000000
rd   f0000000 f 00000000 18000000
rd   f0000004 f 00000000 18209100
rd   f0000034 f 00000000 deadbeef
rd   f000003c f 00000000 89abcdef
rd   f00000fc f 00000000 15000000
pad  00000000 0 00000000 0000000f
wr   91000000 4 00f00000 00000000
wr   91000000 8 a5000000 00000000
wait 00000000 0 00000004 00000000
rd   91000000 8 00000000 a0a0a0a0
rd   91000000 4 00000000 f0f0f0f0
rnd  91000000 8 0000000f 00000000
rnd  91000000 8 0000000f 00000000
pad  00000000 0 00000000 0000000f
wait 00000000 0 00000004 00000000
wr   91000000 1 000000ff 00000000
wr   91000000 2 00000100 00000000
irq  00000000 0 00000001 00000000
pad  00000000 0 00000002 0000000f
irq  00000000 0 00000004 00000000
pad  00000000 0 00000003 0000000f
irq  00000000 0 00000004 00000400
wr   91000000 1 00000001 00000000
irq  00000000 0 00000001 00000000
rd   91000000 1 00000000 02020202

// ==== vlog.f ====
+incdir+include
source/soc_pkg.sv
source/wb_addr_decode.sv
source/wb_data_resize.sv
source/boot_rom.sv
source/gpio_regs.sv
source/gpio_pads.sv
source/orpsoc_top.sv
tb/orpsoc_tb.sv

// ==== Bender.yml ====
package:
  name: orpsoc_wb

sources:
  - include_dirs:
      - include
    files:
      - source/soc_pkg.sv
      - source/wb_addr_decode.sv
      - source/wb_data_resize.sv
      - source/boot_rom.sv
      - source/gpio_regs.sv
      - source/gpio_pads.sv
      - source/orpsoc_top.sv
  - target: test
    files:
      - tb/orpsoc_tb.sv
